/* design/graph_cu_pkg.sv */
// Sizes, buffer depths, array kinds and the job, command and read tag types

package graph_cu_pkg;

	// Unit count and field widths
	parameter int NUM_CU_DEFAULT = 4;
	parameter int CU_ID_BITS     = 4;
	parameter int VERTEX_BITS    = 32;
	parameter int EDGE_BITS      = 32;
	parameter int EDGES_PER_LINE = 8;
	parameter int LINE_EDGE_BITS = 4;

	// Buffer sizing
	parameter int JOB_FIFO_DEPTH   = 16;
	parameter int CMD_FIFO_DEPTH   = 8;
	parameter int BURST_FIFO_DEPTH = 16;
	parameter int FIFO_HEADROOM    = 4;

	// Target array of a read with code 7 left unused
	typedef enum logic [2:0] {
		EDGE_ARRAY_SRC,
		EDGE_ARRAY_DEST,
		EDGE_ARRAY_WEIGHT,
		INV_EDGE_ARRAY_SRC,
		INV_EDGE_ARRAY_DEST,
		INV_EDGE_ARRAY_WEIGHT,
		READ_GRAPH_DATA
	} array_kind_t;

	typedef struct packed {
		logic [VERTEX_BITS-1:0] vertex_id;
		logic [EDGE_BITS-1:0]   edge_start;
		logic [EDGE_BITS-1:0]   out_degree;
	} vertex_job_t;

	typedef struct packed {
		logic [CU_ID_BITS-1:0]     cu_id;
		array_kind_t               kind;
		logic [EDGE_BITS-1:0]      address;
		logic [LINE_EDGE_BITS-1:0] line_edges;
	} read_cmd_t;

	// Tag echoed by memory with each returned line
	typedef struct packed {
		logic [CU_ID_BITS-1:0]     cu_id;
		array_kind_t               kind;
		logic [LINE_EDGE_BITS-1:0] line_edges;
	} read_data_t;

endpackage

/* design/cu_link_if.sv */
// Per-unit link carrying job, read command, returned tag and progress counts
`timescale 1ns/1ps

interface cu_link_if import graph_cu_pkg::*; ();

	// Job hand-off
	logic                   job_valid;
	vertex_job_t            job;
	logic                   job_request;

	// Read commands
	logic                   cmd_valid;
	read_cmd_t              cmd;
	logic                   cmd_alfull;

	// Returned line tags
	logic                   data_valid;
	read_data_t             data;

	// Progress
	logic [VERTEX_BITS-1:0] vertex_count;
	logic [EDGE_BITS-1:0]   edge_count;

	modport unit (
		input  job_valid, job, cmd_alfull, data_valid, data,
		output job_request, cmd_valid, cmd, vertex_count, edge_count
	);
	modport dispatch (output job_valid, job, input job_request);
	modport gather (input cmd_valid, cmd, output cmd_alfull);
	modport route (output data_valid, data);

endinterface

/* design/sync_fifo.sv */
// Synchronous FIFO with first-word output and almost-full headroom
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH    = 8,
	parameter int DEPTH    = 16,
	parameter int HEADROOM = 4
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             valid,
	output logic             empty,
	output logic             full,
	output logic             alfull
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0]   count;
	logic                do_push;
	logic                do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty    = (count == '0);
	assign full     = (count == (PTR_BITS+1)'(DEPTH));
	// Raised once free entries drop to the headroom
	assign alfull   = (count >= (PTR_BITS+1)'(DEPTH - HEADROOM));
	assign valid    = do_pop;
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

endmodule

/* design/rr_arbiter.sv */
// Round-robin arbiter with registered one-hot grant and rotating pointer
`timescale 1ns/1ps

module rr_arbiter #(
	parameter int NUM_REQ = 4
) (
	input  logic               clock,
	input  logic               rstn,
	input  logic               enabled,
	input  logic [NUM_REQ-1:0] requests,
	output logic [NUM_REQ-1:0] grant
);

	localparam int PTR_BITS = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

	logic [PTR_BITS-1:0] ptr;
	logic [PTR_BITS-1:0] winner;
	logic [NUM_REQ-1:0]  pick;
	logic                found;

	// First request at or after the pointer wins
	always_comb begin
		int idx;
		pick   = '0;
		winner = ptr;
		found  = 1'b0;
		for (int k = 0; k < NUM_REQ; k++) begin
			idx = (int'(ptr) + k) % NUM_REQ;
			if (!found && requests[idx]) begin
				pick[idx] = 1'b1;
				winner    = PTR_BITS'(idx);
				found     = 1'b1;
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			grant <= '0;
			ptr   <= '0;
		end else begin
			grant <= enabled ? pick : '0;
			// Step past the winner so it goes last next round
			if (enabled && found)
				ptr <= (winner == PTR_BITS'(NUM_REQ - 1)) ? '0 : winner + 1'b1;
		end
	end

endmodule

/* design/vertex_job_dispatch.sv */
// Vertex job buffer and round-robin hand-off to idle enabled units
`timescale 1ns/1ps

module vertex_job_dispatch import graph_cu_pkg::*; #(
	parameter int NUM_CU = NUM_CU_DEFAULT
) (
	input  logic              clock,
	input  logic              rstn,
	input  logic              enabled,
	input  logic [NUM_CU-1:0] cu_enable,
	input  logic              job_valid,
	input  vertex_job_t       job,
	output logic              job_ready,
	cu_link_if.dispatch       links [NUM_CU]
);

	vertex_job_t       head_job;
	vertex_job_t       job_out;
	logic              head_valid;
	logic              buf_empty;
	logic              buf_alfull;
	logic [NUM_CU-1:0] requests;
	logic [NUM_CU-1:0] grant;
	logic [NUM_CU-1:0] sent;

	assign job_ready = enabled && !buf_alfull;

	sync_fifo #(
		.WIDTH   ($bits(vertex_job_t)),
		.DEPTH   (JOB_FIFO_DEPTH),
		.HEADROOM(FIFO_HEADROOM)
	) job_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_valid && job_ready),
		.data_in (job),
		.pop     (|grant),
		.data_out(head_job),
		.valid   (head_valid),
		.empty   (buf_empty),
		.full    (),
		.alfull  (buf_alfull)
	);

	// No request while a grant or a hand-off is still in flight
	for (genvar i = 0; i < NUM_CU; i++) begin : g_link
		assign requests[i] = cu_enable[i] && links[i].job_request && !buf_empty &&
			!(|grant) && !sent[i];
		assign links[i].job_valid = sent[i];
		assign links[i].job       = job_out;
	end

	rr_arbiter #(.NUM_REQ(NUM_CU)) job_arb (
		.clock   (clock),
		.rstn    (rstn),
		.enabled (enabled),
		.requests(requests),
		.grant   (grant)
	);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			sent <= '0;
		else
			sent <= grant & {NUM_CU{head_valid}};
	end

	always_ff @(posedge clock) begin
		if (head_valid)
			job_out <= head_job;
	end

endmodule

/* design/edge_walker_cu.sv */
// Edge walker unit splitting a vertex job into line reads and counting edges
`timescale 1ns/1ps

module edge_walker_cu import graph_cu_pkg::*; #(
	parameter int CU_ID = 0
) (
	input  logic    clock,
	input  logic    rstn,
	input  logic    enabled,
	cu_link_if.unit link
);

	logic                      busy;
	logic                      start;
	logic                      first_cmd;
	logic                      issue;
	logic                      line_back;
	logic                      finish;
	logic [EDGE_BITS-1:0]      next_addr;
	logic [EDGE_BITS-1:0]      edges_left;
	logic [EDGE_BITS-1:0]      lines_out;
	logic [LINE_EDGE_BITS-1:0] first_size;
	logic [LINE_EDGE_BITS-1:0] line_size;

	// Full line unless fewer edges remain
	function automatic logic [LINE_EDGE_BITS-1:0] line_of(input logic [EDGE_BITS-1:0] left);
		if (left > EDGE_BITS'(EDGES_PER_LINE))
			return LINE_EDGE_BITS'(EDGES_PER_LINE);
		return left[LINE_EDGE_BITS-1:0];
	endfunction

	assign link.job_request = enabled && !busy;

	assign start      = link.job_valid && !busy;
	assign first_cmd  = start && (link.job.out_degree != '0);
	assign first_size = line_of(link.job.out_degree);
	assign line_size  = line_of(edges_left);
	assign issue      = busy && enabled && (edges_left != '0) && !link.cmd_alfull;
	assign line_back  = link.data_valid;
	// Last outstanding line of a fully issued job
	assign finish     = busy && (edges_left == '0) && line_back && (lines_out == EDGE_BITS'(1));

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy              <= 1'b0;
			next_addr         <= '0;
			edges_left        <= '0;
			lines_out         <= '0;
			link.cmd_valid    <= 1'b0;
			link.vertex_count <= '0;
			link.edge_count   <= '0;
		end else begin
			link.cmd_valid <= first_cmd || issue;

			if (first_cmd) begin
				busy       <= 1'b1;
				next_addr  <= link.job.edge_start + EDGE_BITS'(EDGES_PER_LINE);
				edges_left <= link.job.out_degree - EDGE_BITS'(first_size);
			end else if (issue) begin
				next_addr  <= next_addr + EDGE_BITS'(EDGES_PER_LINE);
				edges_left <= edges_left - EDGE_BITS'(line_size);
			end

			// Lines in flight
			if (first_cmd || issue) begin
				if (!line_back)
					lines_out <= lines_out + 1'b1;
			end else if (line_back) begin
				lines_out <= lines_out - 1'b1;
			end

			if (line_back)
				link.edge_count <= link.edge_count + EDGE_BITS'(link.data.line_edges);

			// Empty edge list completes right away
			if (start && !first_cmd)
				link.vertex_count <= link.vertex_count + 1'b1;

			if (finish) begin
				busy              <= 1'b0;
				link.vertex_count <= link.vertex_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (first_cmd) begin
			link.cmd.cu_id      <= CU_ID_BITS'(CU_ID);
			link.cmd.kind       <= EDGE_ARRAY_DEST;
			link.cmd.address    <= link.job.edge_start;
			link.cmd.line_edges <= first_size;
		end else if (issue) begin
			link.cmd.address    <= next_addr;
			link.cmd.line_edges <= line_size;
		end
	end

endmodule

/* design/read_cmd_gather.sv */
// Per-unit read command buffers, round-robin merge and burst buffer
`timescale 1ns/1ps

module read_cmd_gather import graph_cu_pkg::*; #(
	parameter int NUM_CU = NUM_CU_DEFAULT
) (
	input  logic              clock,
	input  logic              rstn,
	input  logic              enabled,
	input  logic [NUM_CU-1:0] cu_enable,
	input  logic              mem_alfull,
	cu_link_if.gather         links [NUM_CU],
	output logic              cmd_valid,
	output read_cmd_t         cmd
);

	read_cmd_t         unit_head [NUM_CU];
	logic [NUM_CU-1:0] unit_empty;
	logic [NUM_CU-1:0] unit_valid;
	logic [NUM_CU-1:0] requests;
	logic [NUM_CU-1:0] grant;
	read_cmd_t         merged;
	read_cmd_t         burst_head;
	logic              burst_empty;
	logic              burst_alfull;
	logic              burst_valid;

	////////////////////
	// Unit buffers
	////////////////////

	for (genvar i = 0; i < NUM_CU; i++) begin : g_unit
		sync_fifo #(
			.WIDTH   ($bits(read_cmd_t)),
			.DEPTH   (CMD_FIFO_DEPTH),
			.HEADROOM(FIFO_HEADROOM)
		) unit_fifo (
			.clock   (clock),
			.rstn    (rstn),
			.push    (links[i].cmd_valid),
			.data_in (links[i].cmd),
			.pop     (grant[i]),
			.data_out(unit_head[i]),
			.valid   (unit_valid[i]),
			.empty   (unit_empty[i]),
			.full    (),
			.alfull  (links[i].cmd_alfull)
		);
		assign requests[i] = cu_enable[i] && !unit_empty[i] && !burst_alfull;
	end

	rr_arbiter #(.NUM_REQ(NUM_CU)) cmd_arb (
		.clock   (clock),
		.rstn    (rstn),
		.enabled (enabled),
		.requests(requests),
		.grant   (grant)
	);

	always_comb begin
		merged = '0;
		for (int k = 0; k < NUM_CU; k++) begin
			if (grant[k])
				merged = unit_head[k];
		end
	end

	////////////////////
	// Burst buffer
	////////////////////

	sync_fifo #(
		.WIDTH   ($bits(read_cmd_t)),
		.DEPTH   (BURST_FIFO_DEPTH),
		.HEADROOM(FIFO_HEADROOM)
	) burst_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (|(grant & unit_valid)),
		.data_in (merged),
		.pop     (enabled && !burst_empty && !mem_alfull),
		.data_out(burst_head),
		.valid   (burst_valid),
		.empty   (burst_empty),
		.full    (),
		.alfull  (burst_alfull)
	);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			cmd_valid <= 1'b0;
		else
			cmd_valid <= burst_valid;
	end

	always_ff @(posedge clock) begin
		if (burst_valid)
			cmd <= burst_head;
	end

endmodule

/* design/read_data_route.sv */
// Read tag latch, edge-array kind filter and steering by unit id
`timescale 1ns/1ps

module read_data_route import graph_cu_pkg::*; #(
	parameter int NUM_CU = NUM_CU_DEFAULT
) (
	input  logic              clock,
	input  logic              rstn,
	input  logic              enabled,
	input  logic [NUM_CU-1:0] cu_enable,
	input  logic              data_valid,
	input  read_data_t        data,
	cu_link_if.route          links [NUM_CU]
);

	read_data_t        data_q;
	read_data_t        route_data;
	logic              valid_q;
	logic              edge_kind;
	logic [NUM_CU-1:0] route_valid;

	// Graph data and unused codes are dropped
	always_comb begin
		case (data.kind)
			EDGE_ARRAY_SRC, EDGE_ARRAY_DEST, EDGE_ARRAY_WEIGHT,
			INV_EDGE_ARRAY_SRC, INV_EDGE_ARRAY_DEST, INV_EDGE_ARRAY_WEIGHT:
				edge_kind = 1'b1;
			default:
				edge_kind = 1'b0;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			valid_q     <= 1'b0;
			route_valid <= '0;
		end else begin
			valid_q <= enabled && data_valid && edge_kind;
			for (int k = 0; k < NUM_CU; k++)
				route_valid[k] <= valid_q && cu_enable[k] && (data_q.cu_id == CU_ID_BITS'(k));
		end
	end

	always_ff @(posedge clock) begin
		data_q     <= data;
		route_data <= data_q;
	end

	for (genvar i = 0; i < NUM_CU; i++) begin : g_link
		assign links[i].data_valid = route_valid[i];
		assign links[i].data       = route_data;
	end

endmodule

/* design/graph_cu_control.sv */
// Graph control top with enable and unit mask, job, command and data paths, done counters
`timescale 1ns/1ps

module graph_cu_control import graph_cu_pkg::*; #(
	parameter int NUM_CU = NUM_CU_DEFAULT
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled_in,
	input  logic [CU_ID_BITS:0]    cu_count,
	input  logic                   job_valid,
	input  vertex_job_t            job,
	output logic                   job_ready,
	output logic                   cmd_valid,
	output read_cmd_t              cmd,
	input  logic                   mem_alfull,
	input  logic                   data_valid,
	input  read_data_t             data,
	output logic [VERTEX_BITS-1:0] vertex_done_count,
	output logic [EDGE_BITS-1:0]   edge_done_count
);

	logic                   enabled;
	logic [CU_ID_BITS:0]    cu_count_q;
	logic [NUM_CU-1:0]      cu_enable;
	logic [VERTEX_BITS-1:0] unit_vertex [NUM_CU];
	logic [EDGE_BITS-1:0]   unit_edge   [NUM_CU];
	logic [VERTEX_BITS-1:0] vertex_sum;
	logic [EDGE_BITS-1:0]   edge_sum;

	cu_link_if link [NUM_CU] ();

	////////////////////
	// Enable and mask
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled    <= 1'b0;
			cu_count_q <= '0;
			cu_enable  <= '0;
		end else begin
			enabled <= enabled_in;
			// Zero means keep the last count
			if (enabled && (cu_count != '0))
				cu_count_q <= cu_count;
			if (enabled) begin
				for (int k = 0; k < NUM_CU; k++)
					cu_enable[k] <= (k < int'(cu_count_q));
			end
		end
	end

	////////////////////
	// Datapath
	////////////////////

	vertex_job_dispatch #(.NUM_CU(NUM_CU)) i_dispatch (
		.clock    (clock),
		.rstn     (rstn),
		.enabled  (enabled),
		.cu_enable(cu_enable),
		.job_valid(job_valid),
		.job      (job),
		.job_ready(job_ready),
		.links    (link)
	);

	for (genvar i = 0; i < NUM_CU; i++) begin : g_cu
		edge_walker_cu #(.CU_ID(i)) i_walker (
			.clock  (clock),
			.rstn   (rstn),
			.enabled(enabled),
			.link   (link[i])
		);
		assign unit_vertex[i] = link[i].vertex_count;
		assign unit_edge[i]   = link[i].edge_count;
	end

	read_cmd_gather #(.NUM_CU(NUM_CU)) i_gather (
		.clock     (clock),
		.rstn      (rstn),
		.enabled   (enabled),
		.cu_enable (cu_enable),
		.mem_alfull(mem_alfull),
		.links     (link),
		.cmd_valid (cmd_valid),
		.cmd       (cmd)
	);

	read_data_route #(.NUM_CU(NUM_CU)) i_route (
		.clock     (clock),
		.rstn      (rstn),
		.enabled   (enabled),
		.cu_enable (cu_enable),
		.data_valid(data_valid),
		.data      (data),
		.links     (link)
	);

	////////////////////
	// Done counters
	////////////////////

	always_comb begin
		vertex_sum = '0;
		edge_sum   = '0;
		for (int k = 0; k < NUM_CU; k++) begin
			vertex_sum = vertex_sum + unit_vertex[k];
			edge_sum   = edge_sum + unit_edge[k];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_count <= '0;
			edge_done_count   <= '0;
		end else begin
			vertex_done_count <= vertex_sum;
			edge_done_count   <= edge_sum;
		end
	end

endmodule

/* include/tb_graph_cu_table.svh */
// Vertex job stimulus table with expected edge, line and vertex totals
`ifndef TB_GRAPH_CU_TABLE_SVH
`define TB_GRAPH_CU_TABLE_SVH

localparam int TB_NUM_JOBS = 12;
localparam int TB_CU_COUNT = 3;

// Edge ranges never overlap so a command maps back to one job
localparam vertex_job_t TB_JOBS [TB_NUM_JOBS] = '{
	'{vertex_id: 0,  edge_start: 0,   out_degree: 20},
	'{vertex_id: 1,  edge_start: 32,  out_degree: 8},
	'{vertex_id: 2,  edge_start: 48,  out_degree: 0},
	'{vertex_id: 3,  edge_start: 64,  out_degree: 13},
	'{vertex_id: 4,  edge_start: 96,  out_degree: 1},
	'{vertex_id: 5,  edge_start: 112, out_degree: 37},
	'{vertex_id: 6,  edge_start: 160, out_degree: 0},
	'{vertex_id: 7,  edge_start: 176, out_degree: 16},
	'{vertex_id: 8,  edge_start: 208, out_degree: 9},
	'{vertex_id: 9,  edge_start: 224, out_degree: 30},
	'{vertex_id: 10, edge_start: 256, out_degree: 3},
	'{vertex_id: 11, edge_start: 272, out_degree: 25}
};

// Totals over the table
localparam int TB_EXP_VERTICES = 12;
localparam int TB_EXP_EDGES    = 162;
localparam int TB_EXP_LINES    = 25;
localparam int TB_ZERO_DEGREE  = 2;

`endif

/* verification/tb_graph_cu_control.sv */
// Testbench for the graph control top with job table loop, memory model, checks and watchdog
`timescale 1ns/1ps

module tb_graph_cu_control import graph_cu_pkg::*; ();

	`include "tb_graph_cu_table.svh"

	localparam int TB_NUM_CU       = 4;
	localparam int WATCHDOG_CYCLES = 400 * TB_NUM_JOBS;
	localparam int INJECT_CYCLE    = 40;
	// Route delay, unit count, sum register, plus margin
	localparam int SETTLE_CYCLES   = 2 + 1 + 1 + 4;

	logic                   clock;
	logic                   rstn;
	logic                   enabled_in;
	logic [CU_ID_BITS:0]    cu_count;
	logic                   job_valid;
	vertex_job_t            job;
	logic                   job_ready;
	logic                   cmd_valid;
	read_cmd_t              cmd;
	logic                   mem_alfull;
	logic                   data_valid;
	read_data_t             data;
	logic [VERTEX_BITS-1:0] vertex_done_count;
	logic [EDGE_BITS-1:0]   edge_done_count;

	integer     seed;
	int         errors;
	int         cycle;
	int         exp_lines;
	int         exp_edges;
	int         cmd_total;
	int         stall_left;
	int         stalled_cmds;
	bit         injected;
	int         owner      [TB_NUM_JOBS];
	int         lines_seen [TB_NUM_JOBS];
	int         reply_due  [$];
	read_data_t reply_tag  [$];

	graph_cu_control #(.NUM_CU(TB_NUM_CU)) i_graph_cu_control (
		.clock            (clock),
		.rstn             (rstn),
		.enabled_in       (enabled_in),
		.cu_count         (cu_count),
		.job_valid        (job_valid),
		.job              (job),
		.job_ready        (job_ready),
		.cmd_valid        (cmd_valid),
		.cmd              (cmd),
		.mem_alfull       (mem_alfull),
		.data_valid       (data_valid),
		.data             (data),
		.vertex_done_count(vertex_done_count),
		.edge_done_count  (edge_done_count)
	);

	always #2 clock = ~clock;

	////////////////////
	// Reporting and checks
	////////////////////

	task automatic report_error(input string msg);
		errors++;
		$display("ERR %0t: %s", $time, msg);
		$display("Verification failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_cmd(input read_cmd_t got, input read_cmd_t want);
		if (got !== want)
			report_error($sformatf("cmd got cu %0d %s addr %0d edges %0d, %s",
				got.cu_id, got.kind.name(), got.address, got.line_edges,
				$sformatf("want cu %0d %s addr %0d edges %0d",
					want.cu_id, want.kind.name(), want.address, want.line_edges)));
	endtask

	task automatic check_count(input logic [EDGE_BITS-1:0] got, input logic [EDGE_BITS-1:0] want,
			input string what);
		if (got !== want)
			report_error($sformatf("%s is %0d, expected %0d", what, got, want));
	endtask

	// Lines needed to cover a degree
	function automatic int line_count(input int degree);
		return (degree + EDGES_PER_LINE - 1) / EDGES_PER_LINE;
	endfunction

	function automatic int find_job(input logic [EDGE_BITS-1:0] addr);
		int hit;
		hit = -1;
		for (int j = 0; j < TB_NUM_JOBS; j++) begin
			if (addr >= TB_JOBS[j].edge_start &&
					addr < TB_JOBS[j].edge_start + TB_JOBS[j].out_degree)
				hit = j;
		end
		return hit;
	endfunction

	////////////////////
	// Memory model
	////////////////////

	// Each command must be the next line of the job that owns its address
	task automatic record_command(input read_cmd_t got);
		read_cmd_t  want;
		read_data_t tag;
		int         j;
		int         left;
		integer     r;
		if (cmd_total >= exp_lines)
			report_error($sformatf("command at %0d after all %0d lines", got.address, exp_lines));
		if (int'(got.cu_id) >= TB_CU_COUNT)
			report_error($sformatf("command from disabled unit %0d", got.cu_id));
		j = find_job(got.address);
		if (j < 0)
			report_error($sformatf("address %0d outside every edge list", got.address));
		if (owner[j] < 0)
			owner[j] = int'(got.cu_id);
		want.cu_id      = CU_ID_BITS'(owner[j]);
		want.kind       = EDGE_ARRAY_DEST;
		want.address    = TB_JOBS[j].edge_start + EDGE_BITS'(EDGES_PER_LINE * lines_seen[j]);
		left            = int'(TB_JOBS[j].edge_start + TB_JOBS[j].out_degree - want.address);
		want.line_edges = LINE_EDGE_BITS'((left > EDGES_PER_LINE) ? EDGES_PER_LINE : left);
		check_cmd(got, want);
		lines_seen[j]++;
		cmd_total++;
		r              = $random(seed);
		tag.cu_id      = got.cu_id;
		tag.kind       = got.kind;
		tag.line_edges = got.line_edges;
		reply_due.push_back(cycle + 1 + (r & 7));
		reply_tag.push_back(tag);
	endtask

	// One reply per cycle with the oldest due reply first
	task automatic drive_reply();
		read_data_t graph_word;
		int         pick;
		pick = -1;
		for (int k = 0; k < reply_due.size(); k++) begin
			if (pick < 0 && reply_due[k] <= cycle)
				pick = k;
		end
		if (pick >= 0) begin
			data_valid <= 1'b1;
			data       <= reply_tag[pick];
			reply_due.delete(pick);
			reply_tag.delete(pick);
		end else if (!injected && cycle >= INJECT_CYCLE) begin
			graph_word.cu_id      = CU_ID_BITS'(1);
			graph_word.kind       = READ_GRAPH_DATA;
			graph_word.line_edges = LINE_EDGE_BITS'(5);
			data_valid <= 1'b1;
			data       <= graph_word;
			injected = 1'b1;
		end else begin
			data_valid <= 1'b0;
		end
	endtask

	// Random stalls of one to sixteen cycles
	task automatic drive_stall();
		integer r;
		if (stall_left > 0) begin
			stall_left--;
			if (stall_left == 0)
				mem_alfull <= 1'b0;
		end else begin
			r = $random(seed);
			if ((r & 15) == 0) begin
				stall_left = 1 + ((r >> 4) & 15);
				mem_alfull <= 1'b1;
			end
		end
	endtask

	always @(posedge clock) begin
		if (rstn) begin
			cycle++;
			if (mem_alfull && cmd_valid) begin
				stalled_cmds++;
				if (stalled_cmds > FIFO_HEADROOM)
					report_error($sformatf("%0d commands while memory almost full", stalled_cmds));
			end else if (!mem_alfull) begin
				stalled_cmds = 0;
			end
			if (cmd_valid)
				record_command(cmd);
			drive_reply();
			drive_stall();
		end
	end

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		int zeros;
		int sent;
		clock        = 1'b0;
		rstn         = 1'b0;
		enabled_in   = 1'b0;
		cu_count     = '0;
		job_valid    = 1'b0;
		job          = '0;
		mem_alfull   = 1'b0;
		data_valid   = 1'b0;
		data         = '0;
		seed         = 32'heddf2805;
		errors       = 0;
		cycle        = 0;
		cmd_total    = 0;
		stall_left   = 0;
		stalled_cmds = 0;
		injected     = 1'b0;
		exp_lines    = 0;
		exp_edges    = 0;
		zeros        = 0;
		for (int j = 0; j < TB_NUM_JOBS; j++) begin
			owner[j]      = -1;
			lines_seen[j] = 0;
			exp_lines += line_count(int'(TB_JOBS[j].out_degree));
			exp_edges += int'(TB_JOBS[j].out_degree);
			if (TB_JOBS[j].out_degree == '0)
				zeros++;
		end
		if (exp_lines != TB_EXP_LINES || exp_edges != TB_EXP_EDGES ||
				zeros != TB_ZERO_DEGREE || TB_EXP_VERTICES != TB_NUM_JOBS)
			abort_run("The stimulus table totals do not match its own job entries");

		repeat (2) @(posedge clock);
		rstn <= 1'b1;
		@(posedge clock);
		enabled_in <= 1'b1;
		cu_count   <= (CU_ID_BITS+1)'(TB_CU_COUNT);
		job_valid  <= 1'b1;
		job        <= TB_JOBS[0];

		// A job is taken on each edge where ready was high
		sent = 0;
		while (sent < TB_NUM_JOBS) begin
			@(posedge clock);
			if (job_ready) begin
				sent++;
				if (sent < TB_NUM_JOBS) begin
					job <= TB_JOBS[sent];
				end else begin
					job_valid <= 1'b0;
					job       <= '0;
				end
			end
		end

		do
			@(negedge clock);
		while (!(cmd_total == exp_lines && reply_due.size() == 0 && injected));
		repeat (SETTLE_CYCLES) @(negedge clock);

		// Zero-degree jobs issue no lines yet still count as done
		check_count(vertex_done_count, TB_EXP_VERTICES, "vertex_done_count");
		check_count(edge_done_count, exp_edges, "edge_done_count");

		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		abort_run($sformatf("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES));
	end

endmodule

/* project.f */
+incdir+include
design/graph_cu_pkg.sv
design/cu_link_if.sv
design/sync_fifo.sv
design/rr_arbiter.sv
design/vertex_job_dispatch.sv
design/edge_walker_cu.sv
design/read_cmd_gather.sv
design/read_data_route.sv
design/graph_cu_control.sv
verification/tb_graph_cu_control.sv

/* Bender.yml */
package:
  name: graph_cu_control

sources:
  - files:
      - design/graph_cu_pkg.sv
      - design/cu_link_if.sv
      - design/sync_fifo.sv
      - design/rr_arbiter.sv
      - design/vertex_job_dispatch.sv
      - design/edge_walker_cu.sv
      - design/read_cmd_gather.sv
      - design/read_data_route.sv
      - design/graph_cu_control.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_graph_cu_control.sv
